// File: testbench/sysctl_tests.txt
# Columns: command, argument a (hex), argument b (hex)
# W addr data | S status{button,phy_int_n,link,clk,rx,tx} 0 | P 0 0 | R index expected
# Expected words of time and PPS indices are taken from the model
W 00 0000001d
W 01 a5a5a50b
W 02 00000006
W 07 ffffffff
W 04 00000001
W 03 000000a5
W 06 0000000f
S 35 0
S 0a 0
W 04 00000000
W 05 00000001
W 05 00000001
W 0a 00000012
W 0b fffffff8
R a 00000000
R b 00000000
R c 00070003
R 3 00000000
S 2c 0
R d 0000001e
P 0 0
R e 00000000
R f 00000000
S 10 0
R d 00000000

// File: verilog.f
src/sysctl_pkg.sv
src/setting_reg.sv
src/misc_ctrl.sv
src/boot_sequencer.sv
src/vita_timer.sv
src/readback_mux.sv
src/sysctl_top.sv
testbench/sysctl_assertions.sv
testbench/tb_sysctl.sv

// File: Makefile
# Verilator build, run and lint of the system control testbench

.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_sysctl > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Simulation passed" sim.log

build:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module tb_sysctl

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module tb_sysctl

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_sysctl.sv
//////////////////////////////////////////////////////////////////////
// Control plane testbench, file-driven settings, status, PPS, readback
//////////////////////////////////////////////////////////////////////

module tb_sysctl;

   import sysctl_pkg::*;

   logic        dsp_clk;
   logic        por_rst;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   logic        run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i;
   logic        phy_int_n_i, button_i, pps_i, rb_stb_i;
   rb_addr_t    rb_addr_i;
   logic [31:0] rb_data_o;
   logic        rb_ack_o, clock_ready_o, phy_reset_n_o, cpu_rst_o, boot_done_o, pps_int_o;
   logic [1:0]  clk_en_o, clk_sel_o;
   logic        ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic        adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic [7:0]  leds_o;

   // Reference model state
   vita_time_t  time_m;
   vita_time_t  pps_m;
   set_data_t   hi_m;
   logic [7:0]  clock_m, serdes_m, adc_m, led_sw_m, led_src_m;
   logic        phy_m, bldr_m, done_m, cpu_rst_m, pps_int_m, pps_prev;
   int          pps_age;
   logic        checking = 1'b0;
   int          errors = 0;
   int          tests = 0;
   int          failed = 0;

   sysctl_top u_sysctl_top (.*);

   bind sysctl_top sysctl_assertions u_sysctl_assertions (
      .dsp_clk, .por_rst, .rb_stb_i, .rb_ack_i(rb_ack_o),
      .cpu_rst_i(cpu_rst_o), .boot_done_i(boot_done_o));

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
      if (got !== expected) begin
         errors++;
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
      end
   endtask

   function automatic logic write_hit(input set_addr_t addr);
      return set_stb_i && (set_addr_i == addr);
   endfunction

   // Source bit 1 takes the hardware status bit
   function automatic logic [7:0] led_expect();
      logic [7:0] hw;
      logic [7:0] leds;
      hw    = 8'h00;
      hw[1] = serdes_link_up_i;
      hw[2] = clk_status_i;
      hw[3] = run_rx_i;
      hw[4] = run_tx_i;
      for (int i = 0; i < 8; i++) leds[i] = led_src_m[i] ? hw[i] : led_sw_m[i];
      return leds;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Reference model stepped on the edges where the DUT samples
   always @(posedge dsp_clk) begin
      if (por_rst) begin
         time_m    = '0;
         {clock_m, serdes_m, adc_m, led_sw_m} = '0;
         led_src_m = LED_SRC_RESET;
         {phy_m, bldr_m, done_m, cpu_rst_m, pps_int_m, pps_prev} = '0;
         pps_age   = 0;
      end else begin
         // Loader flag seen one edge after its write
         cpu_rst_m = bldr_m && !done_m;
         if (cpu_rst_m) done_m = 1'b1;
         if (write_hit(SR_TIME64 + TIME_LO)) time_m = {hi_m, set_data_i};
         else time_m = time_m + 64'd1;
         if (write_hit(SR_TIME64 + TIME_HI)) hi_m = set_data_i;
         // PPS first high at edge p, count of p+1 kept, interrupt after p+2
         pps_int_m = (pps_age == 2);
         if (pps_age == 1) pps_m = time_m;
         pps_age = (pps_age == 1) ? 2 : 0;
         if (pps_i && !pps_prev) pps_age = 1;
         pps_prev = pps_i;
         if (write_hit(SR_MISC + MISC_CLOCK)) clock_m = set_data_i[7:0];
         if (write_hit(SR_MISC + MISC_SERDES)) serdes_m = set_data_i[7:0];
         if (write_hit(SR_MISC + MISC_ADC)) adc_m = set_data_i[7:0];
         if (write_hit(SR_MISC + MISC_LED_SW)) led_sw_m = set_data_i[7:0];
         if (write_hit(SR_MISC + MISC_LED_SRC)) led_src_m = set_data_i[7:0];
         if (write_hit(SR_MISC + MISC_PHY)) phy_m = set_data_i[0];
         if (write_hit(SR_MISC + MISC_BLDR)) bldr_m = set_data_i[0];
      end
   end

   // Outputs compared mid-cycle
   always @(negedge dsp_clk) begin
      if (checking) begin
         compare_value("{clock_ready_o,clk_en_o,clk_sel_o}",
                       64'({clock_ready_o, clk_en_o, clk_sel_o}), 64'(clock_m[4:0]));
         compare_value("{ser_enable_o,ser_prbsen_o,ser_loopen_o,ser_rx_en_o}",
                       64'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
                       64'(serdes_m[3:0]));
         compare_value("{adc_oe_a_o,adc_on_a_o,adc_oe_b_o,adc_on_b_o}",
                       64'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
                       64'(adc_m[3:0]));
         compare_value("phy_reset_n_o", 64'(phy_reset_n_o), 64'(!phy_m));
         compare_value("leds_o", 64'(leds_o), 64'(led_expect()));
         compare_value("cpu_rst_o", 64'(cpu_rst_o), 64'(cpu_rst_m));
         compare_value("boot_done_o", 64'(boot_done_o), 64'(done_m));
         compare_value("pps_int_o", 64'(pps_int_o), 64'(pps_int_m));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      #2;
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(posedge dsp_clk);
      #2;
      set_stb_i = 1'b0;
   endtask

   task automatic apply_status(input logic [5:0] bits);
      @(posedge dsp_clk);
      #2;
      {button_i, phy_int_n_i, serdes_link_up_i, clk_status_i, run_rx_i, run_tx_i} = bits;
   endtask

   task automatic pulse_pps();
      int   waited;
      logic seen;
      @(posedge dsp_clk);
      #2;
      pps_i  = 1'b1;
      seen   = 1'b0;
      waited = 0;
      while (!(seen && waited >= 4) && waited < 16) begin
         @(posedge dsp_clk);
         #2;
         waited++;
         if (pps_int_o) seen = 1'b1;
         if (waited == 4) pps_i = 1'b0;
      end
      if (!seen) begin
         $display("PPS interrupt did not arrive within 16 cycles");
         errors++;
      end
   endtask

   // Time words come from the model and the rest from the file
   task automatic read_word(input rb_addr_t index, input set_data_t file_word);
      set_data_t expected;
      int        waited;
      @(posedge dsp_clk);
      #2;
      rb_stb_i  = 1'b1;
      rb_addr_i = index;
      case (index)
         RB_TIME_HI: expected = time_m[63:32];
         RB_TIME_LO: expected = time_m[31:0];
         RB_PPS_HI:  expected = pps_m[63:32];
         RB_PPS_LO:  expected = pps_m[31:0];
         default:    expected = file_word;
      endcase
      waited = 0;
      do begin
         @(posedge dsp_clk);
         #2;
         rb_stb_i = 1'b0;
         waited++;
      end while (!rb_ack_o && waited < 8);
      if (rb_ack_o) begin
         compare_value("rb_data_o", 64'(rb_data_o), 64'(expected));
      end else begin
         $display("No readback acknowledge for index %0d within 8 cycles", index);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence from file
   initial begin
      int          fd;
      int          errors_before;
      string       line;
      logic [7:0]  cmd;
      logic [31:0] arg_a;
      logic [31:0] arg_b;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      {button_i, phy_int_n_i, serdes_link_up_i, clk_status_i, run_rx_i, run_tx_i} = 6'b010101;
      pps_i     = 1'b0;
      rb_stb_i  = 1'b0;
      rb_addr_i = '0;
      por_rst   = 1'b1;
      repeat (16) @(posedge dsp_clk);
      #2;
      por_rst  = 1'b0;
      checking = 1'b1;
      fd = $fopen("testbench/sysctl_tests.txt", "r");
      if (fd == 0) begin
         $display("Cannot open testbench/sysctl_tests.txt");
         errors++;
      end else begin
         while (!$feof(fd) && tests < 200) begin
            if ($fgets(line, fd) > 0 && line.getc(0) != "#" &&
                $sscanf(line, "%c %h %h", cmd, arg_a, arg_b) == 3) begin
               errors_before = errors;
               tests++;
               case (cmd)
                  "W": write_setting(arg_a[7:0], arg_b);
                  "S": apply_status(arg_a[5:0]);
                  "P": pulse_pps();
                  "R": read_word(arg_a[3:0], arg_b);
                  default: begin
                     $display("Unknown command %c in test file", cmd);
                     errors++;
                  end
               endcase
               // Let late responses land in this test
               repeat (3) @(posedge dsp_clk);
               if (errors != errors_before) failed++;
               $display("test %0d: %c %h %h %s", tests, cmd, arg_a, arg_b,
                        (errors == errors_before) ? "ok" : "FAILED");
            end
         end
         $fclose(fd);
      end
      checking = 1'b0;
      $display("%0d tests run, %0d failed, %0d check errors", tests, failed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: testbench/sysctl_assertions.sv
//////////////////////////////////////////////////////////////////////
// Readback acknowledge and processor reset sequencing rules
//////////////////////////////////////////////////////////////////////

module sysctl_assertions (
   input logic dsp_clk,
   input logic por_rst,
   input logic rb_stb_i,
   input logic rb_ack_i,
   input logic cpu_rst_i,
   input logic boot_done_i
);

   // Acknowledge exactly one cycle behind each strobe
   ack_after_stb: assert property (
      @(posedge dsp_clk) disable iff (por_rst) rb_stb_i |=> rb_ack_i)
      else $error("rb_ack_o missing one cycle after rb_stb_i");

   ack_only_after_stb: assert property (
      @(posedge dsp_clk) disable iff (por_rst) !rb_stb_i |=> !rb_ack_i)
      else $error("rb_ack_o high without a preceding rb_stb_i");

   // Single cycle processor reset pulse
   cpu_rst_single: assert property (
      @(posedge dsp_clk) disable iff (por_rst) cpu_rst_i |=> !cpu_rst_i)
      else $error("cpu_rst_o high for two cycles outside reset");

   boot_done_sticky: assert property (
      @(posedge dsp_clk) disable iff (por_rst) boot_done_i |=> boot_done_i)
      else $error("boot_done_o fell outside reset");

endmodule

// File: src/sysctl_top.sv
//////////////////////////////////////////////////////////////////////
// Control plane top: misc registers, boot sequencer, timer, readback
//////////////////////////////////////////////////////////////////////

module sysctl_top (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_stb_i,
   input  sysctl_pkg::set_addr_t  set_addr_i,
   input  sysctl_pkg::set_data_t  set_data_i,
   input  logic                   run_tx_i,
   input  logic                   run_rx_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   phy_int_n_i,
   input  logic                   button_i,
   input  logic                   pps_i,
   input  logic                   rb_stb_i,
   input  sysctl_pkg::rb_addr_t   rb_addr_i,
   output logic [31:0]            rb_data_o,
   output logic                   rb_ack_o,
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,
   output logic                   ser_enable_o,
   output logic                   ser_prbsen_o,
   output logic                   ser_loopen_o,
   output logic                   ser_rx_en_o,
   output logic                   adc_oe_a_o,
   output logic                   adc_on_a_o,
   output logic                   adc_oe_b_o,
   output logic                   adc_on_b_o,
   output logic                   phy_reset_n_o,
   output logic [7:0]             leds_o,
   output logic                   cpu_rst_o,
   output logic                   boot_done_o,
   output logic                   pps_int_o
);

   logic                   bldr_done;
   sysctl_pkg::vita_time_t vita_time;
   sysctl_pkg::vita_time_t vita_time_pps;
   logic [31:0]            irq;

   // Interrupt sources, PHY line is open drain and active low
   assign irq = {27'd0, button_i, clk_status_i, serdes_link_up_i, ~phy_int_n_i, pps_int_o};

   misc_ctrl u_misc_ctrl (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .run_tx_i, .run_rx_i, .clk_status_i, .serdes_link_up_i,
      .clock_ready_o, .clk_en_o, .clk_sel_o,
      .ser_enable_o, .ser_prbsen_o, .ser_loopen_o, .ser_rx_en_o,
      .adc_oe_a_o, .adc_on_a_o, .adc_oe_b_o, .adc_on_b_o,
      .phy_reset_n_o, .leds_o, .bldr_done_o(bldr_done));

   boot_sequencer u_boot_sequencer (
      .dsp_clk, .por_rst, .bldr_done_i(bldr_done), .cpu_rst_o, .boot_done_o);

   vita_timer u_vita_timer (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i, .pps_i,
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps), .pps_int_o);

   readback_mux u_readback_mux (
      .dsp_clk, .por_rst, .rb_stb_i, .rb_addr_i,
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps), .irq_i(irq),
      .rb_data_o, .rb_ack_o);

endmodule

// File: src/readback_mux.sv
//////////////////////////////////////////////////////////////////////
// Readback word select, registered with a one-cycle acknowledge
//////////////////////////////////////////////////////////////////////

module readback_mux (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    rb_stb_i,
   input  sysctl_pkg::rb_addr_t    rb_addr_i,
   input  sysctl_pkg::vita_time_t  vita_time_i,
   input  sysctl_pkg::vita_time_t  vita_time_pps_i,
   input  logic [31:0]             irq_i,
   output logic [31:0]             rb_data_o,
   output logic                    rb_ack_o
);

   import sysctl_pkg::*;

   logic [31:0] rb_word;

   // Buffer pool status and other unused slots read zero
   always_comb begin
      case (rb_addr_i)
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_IRQ:     rb_word = irq_i;
         RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         default:    rb_word = 32'd0;
      endcase
   end

   // Word held until the next strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= rb_word;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

endmodule

// File: src/vita_timer.sv
//////////////////////////////////////////////////////////////////////
// VITA time counter, settable over the settings bus, PPS time capture
//////////////////////////////////////////////////////////////////////

module vita_timer (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    set_stb_i,
   input  sysctl_pkg::set_addr_t   set_addr_i,
   input  sysctl_pkg::set_data_t   set_data_i,
   input  logic                    pps_i,
   output sysctl_pkg::vita_time_t  vita_time_o,
   output sysctl_pkg::vita_time_t  vita_time_pps_o,
   output logic                    pps_int_o
);

   import sysctl_pkg::*;

   set_data_t time_hi_q;
   logic      wr_hi;
   logic      wr_lo;
   logic      pps_s1;
   logic      pps_s2;
   logic      pps_s3;
   logic      pps_rise;

   assign wr_hi = set_stb_i && (set_addr_i == SR_TIME64 + TIME_HI);
   assign wr_lo = set_stb_i && (set_addr_i == SR_TIME64 + TIME_LO);

   //////////////////////////////////////////////////////////////////////
   // Time count
   // Upper word waits here until the lower word arrives
   always_ff @(posedge dsp_clk) begin
      if (wr_hi) begin
         time_hi_q <= set_data_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
      end else if (wr_lo) begin
         vita_time_o <= {time_hi_q, set_data_i};
      end else begin
         vita_time_o <= vita_time_o + 64'd1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_s1    <= 1'b0;
         pps_s2    <= 1'b0;
         pps_s3    <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_s3    <= pps_s2;
         pps_int_o <= pps_rise;
      end
   end

   assign pps_rise = pps_s2 & ~pps_s3;

   // Time latched in the same cycle as the interrupt
   always_ff @(posedge dsp_clk) begin
      if (pps_rise) begin
         vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

// File: src/boot_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Processor reset sequencer, one reset pulse once the loader is done
//////////////////////////////////////////////////////////////////////

module boot_sequencer (
   input  logic dsp_clk,
   input  logic por_rst,
   input  logic bldr_done_i,
   output logic cpu_rst_o,
   output logic boot_done_o
);

   import sysctl_pkg::*;

   logic state_q;
   logic rst_pulse_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q     <= BLDR_WAIT;
         rst_pulse_q <= 1'b0;
      end else begin
         rst_pulse_q <= 1'b0;
         case (state_q)
            BLDR_WAIT: begin
               // Loader flag restarts the processor from main RAM
               if (bldr_done_i) begin
                  state_q     <= BLDR_DONE;
                  rst_pulse_q <= 1'b1;
               end
            end
            default: begin
               // Stays here until power-on reset
               state_q <= BLDR_DONE;
            end
         endcase
      end
   end

   // Processor also held in reset for the whole power-on reset
   assign cpu_rst_o   = por_rst | rst_pulse_q;
   assign boot_done_o = (state_q == BLDR_DONE);

endmodule

// File: src/misc_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Board control registers: clock gen, SERDES, ADC, PHY reset, LEDs
//////////////////////////////////////////////////////////////////////

module misc_ctrl (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_stb_i,
   input  sysctl_pkg::set_addr_t  set_addr_i,
   input  sysctl_pkg::set_data_t  set_data_i,
   input  logic                   run_tx_i,
   input  logic                   run_rx_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,
   output logic                   ser_enable_o,
   output logic                   ser_prbsen_o,
   output logic                   ser_loopen_o,
   output logic                   ser_rx_en_o,
   output logic                   adc_oe_a_o,
   output logic                   adc_on_a_o,
   output logic                   adc_oe_b_o,
   output logic                   adc_on_b_o,
   output logic                   phy_reset_n_o,
   output logic [7:0]             leds_o,
   output logic                   bldr_done_o
);

   import sysctl_pkg::*;

   misc_word_u clock_word;
   misc_word_u serdes_word;
   misc_word_u adc_word;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;
   logic       phy_reset;

   //////////////////////////////////////////////////////////////////////
   // Register bank
   setting_reg #(.ADDR(SR_MISC + MISC_CLOCK), .WIDTH(8)) u_sr_clock (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(clock_word), .changed_o());

   setting_reg #(.ADDR(SR_MISC + MISC_SERDES), .WIDTH(8)) u_sr_serdes (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(serdes_word), .changed_o());

   setting_reg #(.ADDR(SR_MISC + MISC_ADC), .WIDTH(8)) u_sr_adc (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(adc_word), .changed_o());

   setting_reg #(.ADDR(SR_MISC + MISC_LED_SW), .WIDTH(8)) u_sr_led_sw (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(led_sw), .changed_o());

   setting_reg #(.ADDR(SR_MISC + MISC_PHY), .WIDTH(1)) u_sr_phy (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(phy_reset), .changed_o());

   setting_reg #(.ADDR(SR_MISC + MISC_BLDR), .WIDTH(1)) u_sr_bldr (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(bldr_done_o), .changed_o());

   setting_reg #(.ADDR(SR_MISC + MISC_LED_SRC), .WIDTH(8), .AT_RESET(LED_SRC_RESET))
   u_sr_led_src (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(led_src), .changed_o());

   //////////////////////////////////////////////////////////////////////
   // Pin decoding
   assign clock_ready_o = clock_word.clock.clock_ready;
   assign clk_en_o      = clock_word.clock.clk_en;
   assign clk_sel_o     = clock_word.clock.clk_sel;

   assign ser_enable_o = serdes_word.serdes.enable;
   assign ser_prbsen_o = serdes_word.serdes.prbsen;
   assign ser_loopen_o = serdes_word.serdes.loopen;
   assign ser_rx_en_o  = serdes_word.serdes.rx_en;

   assign adc_oe_a_o = adc_word.adc.oe_a;
   assign adc_on_a_o = adc_word.adc.on_a;
   assign adc_oe_b_o = adc_word.adc.oe_b;
   assign adc_on_b_o = adc_word.adc.on_b;

   // PHY pin is active low
   assign phy_reset_n_o = ~phy_reset;

   // Source bit 1 picks hardware, 0 picks software
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: src/setting_reg.sv
//////////////////////////////////////////////////////////////////////
// Settings bus register at one address, with a one-cycle change pulse
//////////////////////////////////////////////////////////////////////

module setting_reg #(
   parameter sysctl_pkg::set_addr_t ADDR     = '0,
   parameter int                    WIDTH    = 32,
   parameter logic [WIDTH-1:0]      AT_RESET = '0
) (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_stb_i,
   input  sysctl_pkg::set_addr_t  set_addr_i,
   input  sysctl_pkg::set_data_t  set_data_i,
   output logic [WIDTH-1:0]       out_o,
   output logic                   changed_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == ADDR);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         out_o     <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         // Low bits only, upper data bits are ignored
         if (hit) begin
            out_o <= set_data_i[WIDTH-1:0];
         end
         changed_o <= hit;
      end
   end

endmodule

// File: src/sysctl_pkg.sv
//////////////////////////////////////////////////////////////////////
// System control package: settings map, readback map, widths and
// the misc control byte layouts shared by the control plane blocks
//////////////////////////////////////////////////////////////////////

package sysctl_pkg;

   // Bus and counter widths
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [3:0]  rb_addr_t;

   //////////////////////////////////////////////////////////////////////
   // Settings address map
   localparam set_addr_t SR_MISC      = 8'd0;
   localparam set_addr_t MISC_CLOCK   = 8'd0;
   localparam set_addr_t MISC_SERDES  = 8'd1;
   localparam set_addr_t MISC_ADC     = 8'd2;
   localparam set_addr_t MISC_LED_SW  = 8'd3;
   localparam set_addr_t MISC_PHY     = 8'd4;
   localparam set_addr_t MISC_BLDR    = 8'd5;
   localparam set_addr_t MISC_LED_SRC = 8'd6;

   localparam set_addr_t SR_TIME64 = 8'd10;
   localparam set_addr_t TIME_HI   = 8'd0;
   localparam set_addr_t TIME_LO   = 8'd1;

   // Hardware drives LEDs 1 to 4 out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'b0001_1110;

   // Major in upper half, minor in lower half
   localparam set_data_t COMPAT_NUM = {16'd7, 16'd3};

   // Boot sequencer states
   localparam logic BLDR_WAIT = 1'b0;
   localparam logic BLDR_DONE = 1'b1;

   //////////////////////////////////////////////////////////////////////
   // Readback word indices
   localparam rb_addr_t RB_TIME_HI = 4'd10;
   localparam rb_addr_t RB_TIME_LO = 4'd11;
   localparam rb_addr_t RB_COMPAT  = 4'd12;
   localparam rb_addr_t RB_IRQ     = 4'd13;
   localparam rb_addr_t RB_PPS_HI  = 4'd14;
   localparam rb_addr_t RB_PPS_LO  = 4'd15;

   // Misc control byte, one layout per register
   typedef union packed {
      struct packed {
         logic [2:0] rsvd;
         logic       clock_ready;
         logic [1:0] clk_en;
         logic [1:0] clk_sel;
      } clock;
      struct packed {
         logic [3:0] rsvd;
         logic       enable;
         logic       prbsen;
         logic       loopen;
         logic       rx_en;
      } serdes;
      struct packed {
         logic [3:0] rsvd;
         logic       oe_a;
         logic       on_a;
         logic       oe_b;
         logic       on_b;
      } adc;
   } misc_word_u;

endpackage
